/* build.f */
hdl/ucie_log_event_pkg.sv
hdl/ucie_log_csr_pkg.sv
hdl/ucie_log_event_detect.sv
hdl/ucie_log_error_accum.sv
hdl/ucie_log_csr_writer.sv
hdl/ucie_log_top.sv
testbench/tb_clock_gen.sv
testbench/ucie_log_assertions.sv
testbench/ucie_log_tb.sv

/* hdl/ucie_log_csr_pkg.sv */
package ucie_log_csr_pkg;

  // CSR write port widths
  localparam int CSR_DATA_W = 32;
  localparam int CSR_ADDR_W = 8;

  // Status register addresses
  localparam logic [CSR_ADDR_W-1:0] REG_INTERNAL_ERROR_STATUS = 8'h24;
  localparam logic [CSR_ADDR_W-1:0] REG_ADAPTER_ERROR_STATUS  = 8'h2c;
  localparam logic [CSR_ADDR_W-1:0] REG_UNCORR_ERROR_STATUS   = 8'h34;

  // Internal error status bits, bit 5 reserved
  localparam int INT_SRC_BIT         = 0;
  localparam int INT_DST_BIT         = 1;
  localparam int INT_OPCODE_BIT      = 2;
  localparam int INT_UNSUPPORTED_BIT = 3;
  localparam int INT_PARITY_BIT      = 4;
  localparam int INT_TX_OVERFLOW_BIT = 6;
  localparam int INT_RX_OVERFLOW_BIT = 7;

  // Adapter error status bits
  localparam int ADP_PARAM_TIMEOUT_BIT = 0;
  localparam int ADP_STATE_TIMEOUT_BIT = 1;

  // Uncorrectable error status bits
  localparam int UNC_ADAPTER_TIMEOUT_BIT = 0;
  localparam int UNC_RX_OVERFLOW_BIT     = 1;
  localparam int UNC_INTERNAL_BIT        = 2;
  localparam int UNC_SB_FATAL_BIT        = 3;
  localparam int UNC_SB_NON_FATAL_BIT    = 4;
  localparam int UNC_INVALID_PARAM_BIT   = 5;

  // Status word selector, also the writer state
  typedef enum logic [1:0] {
    LOG_NONE,
    LOG_INTERNAL,
    LOG_UNCORR,
    LOG_ADAPTER
  } log_sel_e;

endpackage

/* hdl/ucie_log_csr_writer.sv */
`timescale 1ns/10ps

module ucie_log_csr_writer (
  input  logic                                    i_clk,
  input  logic                                    i_rst,
  input  logic [ucie_log_csr_pkg::CSR_DATA_W-1:0] i_internal_sts,
  input  logic [ucie_log_csr_pkg::CSR_DATA_W-1:0] i_uncorr_sts,
  input  logic [ucie_log_csr_pkg::CSR_DATA_W-1:0] i_adapter_sts,
  output ucie_log_csr_pkg::log_sel_e              o_clr_sel,
  output logic                                    o_csr_wr,
  output logic [ucie_log_csr_pkg::CSR_ADDR_W-1:0] o_csr_addr,
  output logic [ucie_log_csr_pkg::CSR_DATA_W-1:0] o_csr_wdata
);

  ucie_log_csr_pkg::log_sel_e r_state;
  ucie_log_csr_pkg::log_sel_e w_next_state;

  logic w_int_pend;
  logic w_uncorr_pend;
  logic w_adapter_pend;

  // A word is pending when non-zero and not written this cycle
  assign w_int_pend     = (|i_internal_sts) &&
                          (r_state != ucie_log_csr_pkg::LOG_INTERNAL);
  assign w_uncorr_pend  = (|i_uncorr_sts) &&
                          (r_state != ucie_log_csr_pkg::LOG_UNCORR);
  assign w_adapter_pend = (|i_adapter_sts) &&
                          (r_state != ucie_log_csr_pkg::LOG_ADAPTER);

  // Fixed priority: internal, uncorrectable, adapter
  always_comb begin
    if (w_int_pend) begin
      w_next_state = ucie_log_csr_pkg::LOG_INTERNAL;
    end else if (w_uncorr_pend) begin
      w_next_state = ucie_log_csr_pkg::LOG_UNCORR;
    end else if (w_adapter_pend) begin
      w_next_state = ucie_log_csr_pkg::LOG_ADAPTER;
    end else begin
      w_next_state = ucie_log_csr_pkg::LOG_NONE;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      r_state <= ucie_log_csr_pkg::LOG_NONE;
    end else begin
      r_state <= w_next_state;
    end
  end

  // Clear goes back with the write of the same word
  assign o_clr_sel = r_state;

  // Write strobe, address and live word value per state
  always_comb begin
    o_csr_wr    = 1'b0;
    o_csr_addr  = '0;
    o_csr_wdata = '0;
    case (r_state)
      ucie_log_csr_pkg::LOG_INTERNAL: begin
        o_csr_wr    = 1'b1;
        o_csr_addr  = ucie_log_csr_pkg::REG_INTERNAL_ERROR_STATUS;
        o_csr_wdata = i_internal_sts;
      end
      ucie_log_csr_pkg::LOG_UNCORR: begin
        o_csr_wr    = 1'b1;
        o_csr_addr  = ucie_log_csr_pkg::REG_UNCORR_ERROR_STATUS;
        o_csr_wdata = i_uncorr_sts;
      end
      ucie_log_csr_pkg::LOG_ADAPTER: begin
        o_csr_wr    = 1'b1;
        o_csr_addr  = ucie_log_csr_pkg::REG_ADAPTER_ERROR_STATUS;
        o_csr_wdata = i_adapter_sts;
      end
      default: begin
        // Idle, nothing on the bus
        o_csr_wr    = 1'b0;
      end
    endcase
  end

endmodule

/* hdl/ucie_log_error_accum.sv */
`timescale 1ns/10ps

module ucie_log_error_accum (
  input  logic                                      i_clk,
  input  logic                                      i_rst,
  input  logic [ucie_log_event_pkg::EVT_COUNT-1:0]  i_evt,
  input  ucie_log_csr_pkg::log_sel_e                i_clr_sel,
  output logic [ucie_log_csr_pkg::CSR_DATA_W-1:0]   o_internal_sts,
  output logic [ucie_log_csr_pkg::CSR_DATA_W-1:0]   o_uncorr_sts,
  output logic [ucie_log_csr_pkg::CSR_DATA_W-1:0]   o_adapter_sts
);

  logic [ucie_log_csr_pkg::CSR_DATA_W-1:0] w_int_set;
  logic [ucie_log_csr_pkg::CSR_DATA_W-1:0] w_uncorr_set;
  logic [ucie_log_csr_pkg::CSR_DATA_W-1:0] w_adapter_set;

  // Internal error bits
  always_comb begin
    w_int_set = '0;
    w_int_set[ucie_log_csr_pkg::INT_SRC_BIT] =
      i_evt[ucie_log_event_pkg::EVT_SB_SRC];
    w_int_set[ucie_log_csr_pkg::INT_DST_BIT] =
      i_evt[ucie_log_event_pkg::EVT_SB_DST];
    w_int_set[ucie_log_csr_pkg::INT_OPCODE_BIT] =
      i_evt[ucie_log_event_pkg::EVT_SB_OPCODE];
    w_int_set[ucie_log_csr_pkg::INT_UNSUPPORTED_BIT] =
      i_evt[ucie_log_event_pkg::EVT_SB_UNSUPPORTED];
    w_int_set[ucie_log_csr_pkg::INT_PARITY_BIT] =
      i_evt[ucie_log_event_pkg::EVT_SB_PARITY];
    w_int_set[ucie_log_csr_pkg::INT_TX_OVERFLOW_BIT] =
      i_evt[ucie_log_event_pkg::EVT_TX_OVERFLOW];
    w_int_set[ucie_log_csr_pkg::INT_RX_OVERFLOW_BIT] =
      i_evt[ucie_log_event_pkg::EVT_RX_OVERFLOW];
  end

  // Adapter error bits
  always_comb begin
    w_adapter_set = '0;
    w_adapter_set[ucie_log_csr_pkg::ADP_PARAM_TIMEOUT_BIT] =
      i_evt[ucie_log_event_pkg::EVT_PARAM_TIMEOUT];
    w_adapter_set[ucie_log_csr_pkg::ADP_STATE_TIMEOUT_BIT] =
      i_evt[ucie_log_event_pkg::EVT_STATE_TIMEOUT];
  end

  // Uncorrectable error bits
  always_comb begin
    w_uncorr_set = '0;
    w_uncorr_set[ucie_log_csr_pkg::UNC_ADAPTER_TIMEOUT_BIT] =
      i_evt[ucie_log_event_pkg::EVT_ADAPTER_TIMEOUT];
    // rx overflow is also logged as an internal error
    w_uncorr_set[ucie_log_csr_pkg::UNC_RX_OVERFLOW_BIT] =
      i_evt[ucie_log_event_pkg::EVT_RX_OVERFLOW];
    // Summary of every internal sideband or overflow error
    w_uncorr_set[ucie_log_csr_pkg::UNC_INTERNAL_BIT] = |w_int_set;
    w_uncorr_set[ucie_log_csr_pkg::UNC_SB_FATAL_BIT] =
      i_evt[ucie_log_event_pkg::EVT_SB_FATAL];
    w_uncorr_set[ucie_log_csr_pkg::UNC_SB_NON_FATAL_BIT] =
      i_evt[ucie_log_event_pkg::EVT_SB_NON_FATAL];
    w_uncorr_set[ucie_log_csr_pkg::UNC_INVALID_PARAM_BIT] =
      i_evt[ucie_log_event_pkg::EVT_INVALID_PARAM];
  end

  // Sticky words, a clear keeps bits that arrive in the same cycle
  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      o_internal_sts <= '0;
      o_uncorr_sts   <= '0;
      o_adapter_sts  <= '0;
    end else begin
      if (i_clr_sel == ucie_log_csr_pkg::LOG_INTERNAL) begin
        o_internal_sts <= w_int_set;
      end else begin
        o_internal_sts <= o_internal_sts | w_int_set;
      end

      if (i_clr_sel == ucie_log_csr_pkg::LOG_UNCORR) begin
        o_uncorr_sts <= w_uncorr_set;
      end else begin
        o_uncorr_sts <= o_uncorr_sts | w_uncorr_set;
      end

      if (i_clr_sel == ucie_log_csr_pkg::LOG_ADAPTER) begin
        o_adapter_sts <= w_adapter_set;
      end else begin
        o_adapter_sts <= o_adapter_sts | w_adapter_set;
      end
    end
  end

endmodule

/* hdl/ucie_log_event_detect.sv */
`timescale 1ns/10ps

module ucie_log_event_detect (
  input  logic i_clk,
  input  logic i_rst,

  // Physical layer and adapter levels
  input  logic i_rdi_pl_error,
  input  logic i_rdi_pl_cerror,
  input  logic i_rdi_pl_nferror,
  input  logic i_rdi_pl_trainerror,
  input  logic i_rdi_pl_phyinrecenter,
  input  logic i_cntl_phyinrecenter,

  // Sideband
  input  logic                                       i_sb_pl_valid,
  input  logic [ucie_log_event_pkg::SB_DECODE_W-1:0] i_sb_pl_decode,
  input  logic                                       i_sb_src_error,
  input  logic                                       i_sb_dst_error,
  input  logic                                       i_sb_opcode_error,
  input  logic                                       i_sb_unsupported_message,
  input  logic                                       i_sb_parity_error,

  // Timeouts
  input  logic i_cntl_parameter_exchange_timeout,
  input  logic i_cntl_state_status_transition_timeout,
  input  logic i_cntl_adapter_timeout,
  input  logic i_cntl_invalid_parameter_exchange,

  // Overflows
  input  logic i_tx_over_flow,
  input  logic i_rx_over_flow,

  // FDI forwarding
  output logic o_fdi_pl_error,
  output logic o_fdi_pl_cerror,
  output logic o_fdi_pl_nferror,
  output logic o_fdi_pl_trainerror,
  output logic o_fdi_pl_phyinrecenter,

  output logic [ucie_log_event_pkg::EVT_COUNT-1:0] o_evt
);

  logic                                     w_sb_fatal;
  logic                                     w_sb_non_fatal;
  logic [ucie_log_event_pkg::EVT_COUNT-1:0] w_lvl;
  logic [ucie_log_event_pkg::EVT_COUNT-1:0] r_prev;

  // Error levels go straight through to the protocol layer
  assign o_fdi_pl_error   = i_rdi_pl_error;
  assign o_fdi_pl_cerror  = i_rdi_pl_cerror;
  assign o_fdi_pl_nferror = i_rdi_pl_nferror;

  // Adapter adds its own negotiation failure and recentering
  assign o_fdi_pl_trainerror    = i_rdi_pl_trainerror | i_cntl_invalid_parameter_exchange;
  assign o_fdi_pl_phyinrecenter = i_rdi_pl_phyinrecenter | i_cntl_phyinrecenter;

  // Received sideband error messages
  assign w_sb_fatal     = i_sb_pl_valid &&
                          (i_sb_pl_decode == ucie_log_event_pkg::SB_MSG_FATAL);
  assign w_sb_non_fatal = i_sb_pl_valid &&
                          (i_sb_pl_decode == ucie_log_event_pkg::SB_MSG_NON_FATAL);

  // Gather the levels into event order
  always_comb begin
    w_lvl = '0;
    w_lvl[ucie_log_event_pkg::EVT_SB_SRC]          = i_sb_src_error;
    w_lvl[ucie_log_event_pkg::EVT_SB_DST]          = i_sb_dst_error;
    w_lvl[ucie_log_event_pkg::EVT_SB_OPCODE]       = i_sb_opcode_error;
    w_lvl[ucie_log_event_pkg::EVT_SB_UNSUPPORTED]  = i_sb_unsupported_message;
    w_lvl[ucie_log_event_pkg::EVT_SB_PARITY]       = i_sb_parity_error;
    w_lvl[ucie_log_event_pkg::EVT_TX_OVERFLOW]     = i_tx_over_flow;
    w_lvl[ucie_log_event_pkg::EVT_RX_OVERFLOW]     = i_rx_over_flow;
    w_lvl[ucie_log_event_pkg::EVT_PARAM_TIMEOUT]   = i_cntl_parameter_exchange_timeout;
    w_lvl[ucie_log_event_pkg::EVT_STATE_TIMEOUT]   = i_cntl_state_status_transition_timeout;
    w_lvl[ucie_log_event_pkg::EVT_ADAPTER_TIMEOUT] = i_cntl_adapter_timeout;
    w_lvl[ucie_log_event_pkg::EVT_INVALID_PARAM]   = i_cntl_invalid_parameter_exchange;
    w_lvl[ucie_log_event_pkg::EVT_SB_NON_FATAL]    = w_sb_non_fatal;
    w_lvl[ucie_log_event_pkg::EVT_SB_FATAL]        = w_sb_fatal;
  end

  // Rising edge gives a single registered pulse
  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      r_prev <= '0;
      o_evt  <= '0;
    end else begin
      r_prev <= w_lvl;
      o_evt  <= w_lvl & ~r_prev;
    end
  end

endmodule

/* hdl/ucie_log_event_pkg.sv */
package ucie_log_event_pkg;

  // Width of the sideband message decode field
  localparam int SB_DECODE_W = 5;

  // Sideband error message decodes that are logged
  typedef enum logic [SB_DECODE_W-1:0] {
    SB_MSG_NON_FATAL = 5'b11101,
    SB_MSG_FATAL     = 5'b11110
  } sb_msg_e;

  // Number of one-cycle events passed to the accumulator
  localparam int EVT_COUNT = 13;

  // Sideband link errors
  localparam int EVT_SB_SRC          = 0;
  localparam int EVT_SB_DST          = 1;
  localparam int EVT_SB_OPCODE       = 2;
  localparam int EVT_SB_UNSUPPORTED  = 3;
  localparam int EVT_SB_PARITY       = 4;

  // Buffer overflows
  localparam int EVT_TX_OVERFLOW     = 5;
  localparam int EVT_RX_OVERFLOW     = 6;

  // Adapter timeouts and negotiation failure
  localparam int EVT_PARAM_TIMEOUT   = 7;
  localparam int EVT_STATE_TIMEOUT   = 8;
  localparam int EVT_ADAPTER_TIMEOUT = 9;
  localparam int EVT_INVALID_PARAM   = 10;

  // Received sideband error messages
  localparam int EVT_SB_NON_FATAL    = 11;
  localparam int EVT_SB_FATAL        = 12;

endpackage

/* hdl/ucie_log_top.sv */
`timescale 1ns/10ps

module ucie_log_top (
  input  logic i_clk,
  input  logic i_rst,

  // Physical layer and adapter levels
  input  logic i_rdi_pl_error,
  input  logic i_rdi_pl_cerror,
  input  logic i_rdi_pl_nferror,
  input  logic i_rdi_pl_trainerror,
  input  logic i_rdi_pl_phyinrecenter,
  input  logic i_cntl_phyinrecenter,

  // Sideband
  input  logic                                       i_sb_pl_valid,
  input  logic [ucie_log_event_pkg::SB_DECODE_W-1:0] i_sb_pl_decode,
  input  logic                                       i_sb_src_error,
  input  logic                                       i_sb_dst_error,
  input  logic                                       i_sb_opcode_error,
  input  logic                                       i_sb_unsupported_message,
  input  logic                                       i_sb_parity_error,

  // Timeouts
  input  logic i_cntl_parameter_exchange_timeout,
  input  logic i_cntl_state_status_transition_timeout,
  input  logic i_cntl_adapter_timeout,
  input  logic i_cntl_invalid_parameter_exchange,

  // Overflows
  input  logic i_tx_over_flow,
  input  logic i_rx_over_flow,

  // FDI
  output logic o_fdi_pl_error,
  output logic o_fdi_pl_cerror,
  output logic o_fdi_pl_nferror,
  output logic o_fdi_pl_trainerror,
  output logic o_fdi_pl_phyinrecenter,

  // CSR write port
  output logic                                    o_csr_wr,
  output logic [ucie_log_csr_pkg::CSR_ADDR_W-1:0] o_csr_addr,
  output logic [ucie_log_csr_pkg::CSR_DATA_W-1:0] o_csr_wdata
);

  logic [ucie_log_event_pkg::EVT_COUNT-1:0] w_evt;
  logic [ucie_log_csr_pkg::CSR_DATA_W-1:0]  w_internal_sts;
  logic [ucie_log_csr_pkg::CSR_DATA_W-1:0]  w_uncorr_sts;
  logic [ucie_log_csr_pkg::CSR_DATA_W-1:0]  w_adapter_sts;
  ucie_log_csr_pkg::log_sel_e               w_clr_sel;

  // Stage 1, forwarding and edge events
  ucie_log_event_detect u_event_detect (
    .i_clk                                  (i_clk),
    .i_rst                                  (i_rst),
    .i_rdi_pl_error                         (i_rdi_pl_error),
    .i_rdi_pl_cerror                        (i_rdi_pl_cerror),
    .i_rdi_pl_nferror                       (i_rdi_pl_nferror),
    .i_rdi_pl_trainerror                    (i_rdi_pl_trainerror),
    .i_rdi_pl_phyinrecenter                 (i_rdi_pl_phyinrecenter),
    .i_cntl_phyinrecenter                   (i_cntl_phyinrecenter),
    .i_sb_pl_valid                          (i_sb_pl_valid),
    .i_sb_pl_decode                         (i_sb_pl_decode),
    .i_sb_src_error                         (i_sb_src_error),
    .i_sb_dst_error                         (i_sb_dst_error),
    .i_sb_opcode_error                      (i_sb_opcode_error),
    .i_sb_unsupported_message               (i_sb_unsupported_message),
    .i_sb_parity_error                      (i_sb_parity_error),
    .i_cntl_parameter_exchange_timeout      (i_cntl_parameter_exchange_timeout),
    .i_cntl_state_status_transition_timeout (i_cntl_state_status_transition_timeout),
    .i_cntl_adapter_timeout                 (i_cntl_adapter_timeout),
    .i_cntl_invalid_parameter_exchange      (i_cntl_invalid_parameter_exchange),
    .i_tx_over_flow                         (i_tx_over_flow),
    .i_rx_over_flow                         (i_rx_over_flow),
    .o_fdi_pl_error                         (o_fdi_pl_error),
    .o_fdi_pl_cerror                        (o_fdi_pl_cerror),
    .o_fdi_pl_nferror                       (o_fdi_pl_nferror),
    .o_fdi_pl_trainerror                    (o_fdi_pl_trainerror),
    .o_fdi_pl_phyinrecenter                 (o_fdi_pl_phyinrecenter),
    .o_evt                                  (w_evt)
  );

  // Stage 2, sticky status words
  ucie_log_error_accum u_error_accum (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_evt          (w_evt),
    .i_clr_sel      (w_clr_sel),
    .o_internal_sts (w_internal_sts),
    .o_uncorr_sts   (w_uncorr_sts),
    .o_adapter_sts  (w_adapter_sts)
  );

  // Stage 3, CSR writes
  ucie_log_csr_writer u_csr_writer (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_internal_sts (w_internal_sts),
    .i_uncorr_sts   (w_uncorr_sts),
    .i_adapter_sts  (w_adapter_sts),
    .o_clr_sel      (w_clr_sel),
    .o_csr_wr       (o_csr_wr),
    .o_csr_addr     (o_csr_addr),
    .o_csr_wdata    (o_csr_wdata)
  );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst
);

  localparam int PERIOD_NS    = 10;
  localparam int RESET_CYCLES = 2;

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Active low reset for the first cycles
  initial begin
    o_rst = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_rst <= 1'b1;
  end

endmodule

/* testbench/ucie_log_assertions.sv */
`timescale 1ns/10ps

module ucie_log_assertions (
  input logic                                    i_clk,
  input logic                                    i_rst,
  input logic                                    i_csr_wr,
  input logic [ucie_log_csr_pkg::CSR_ADDR_W-1:0] i_csr_addr,
  input logic [ucie_log_csr_pkg::CSR_DATA_W-1:0] i_csr_wdata
);

  // Number of failed assertions so far
  int fail_count = 0;

  // Only the three status registers are targets
  a_addr_known: assert property (
    @(posedge i_clk) disable iff (!i_rst)
    i_csr_wr |-> (i_csr_addr == ucie_log_csr_pkg::REG_INTERNAL_ERROR_STATUS ||
                  i_csr_addr == ucie_log_csr_pkg::REG_UNCORR_ERROR_STATUS ||
                  i_csr_addr == ucie_log_csr_pkg::REG_ADAPTER_ERROR_STATUS)
  ) else begin
    fail_count = fail_count + 1;
    $error("CSR write to an address outside the status registers");
  end

  // Every write carries at least one logged bit
  a_data_nonzero: assert property (
    @(posedge i_clk) disable iff (!i_rst)
    i_csr_wr |-> (i_csr_wdata != '0)
  ) else begin
    fail_count = fail_count + 1;
    $error("CSR write with an all-zero status word");
  end

  // Word being written is skipped on the next pick
  a_no_repeat: assert property (
    @(posedge i_clk) disable iff (!i_rst)
    i_csr_wr |=> !(i_csr_wr && (i_csr_addr == $past(i_csr_addr)))
  ) else begin
    fail_count = fail_count + 1;
    $error("Same status register written in two consecutive cycles");
  end

endmodule

bind ucie_log_csr_writer ucie_log_assertions u_assertions (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_csr_wr    (o_csr_wr),
  .i_csr_addr  (o_csr_addr),
  .i_csr_wdata (o_csr_wdata)
);

/* testbench/ucie_log_tb.sv */
`timescale 1ns/10ps

module ucie_log_tb;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_BURSTS = 40;
  localparam int NUM_PHASES = NUM_BURSTS + 16;
  localparam int QUIET      = 8;
  localparam int TIMEOUT_NS = (NUM_PHASES * (2 + QUIET) + 500) * CLK_PERIOD;

  // Register addresses as given by the register map
  localparam logic [7:0] ADDR_INT = 8'h24;
  localparam logic [7:0] ADDR_UNC = 8'h34;
  localparam logic [7:0] ADDR_ADP = 8'h2c;

  logic clk;
  logic rst;
  logic rdi_error;
  logic rdi_cerror;
  logic rdi_nferror;
  logic rdi_trainerror;
  logic rdi_recenter;
  logic cntl_recenter;
  logic sb_valid;
  logic [4:0] sb_decode;
  // Direct event levels, indexed like the event vector
  logic [ucie_log_event_pkg::EVT_COUNT-1:0] lvl;
  logic fdi_error;
  logic fdi_cerror;
  logic fdi_nferror;
  logic fdi_trainerror;
  logic fdi_recenter;
  logic        csr_wr;
  logic [7:0]  csr_addr;
  logic [31:0] csr_wdata;
  logic [31:0] exp_int;
  logic [31:0] exp_unc;
  logic [31:0] exp_adp;
  int          write_count;
  integer      seed;

  tb_clock_gen u_clock_gen (
    .o_clk (clk),
    .o_rst (rst)
  );

  ucie_log_top i_dut (
    .i_clk                                  (clk),
    .i_rst                                  (rst),
    .i_rdi_pl_error                         (rdi_error),
    .i_rdi_pl_cerror                        (rdi_cerror),
    .i_rdi_pl_nferror                       (rdi_nferror),
    .i_rdi_pl_trainerror                    (rdi_trainerror),
    .i_rdi_pl_phyinrecenter                 (rdi_recenter),
    .i_cntl_phyinrecenter                   (cntl_recenter),
    .i_sb_pl_valid                          (sb_valid),
    .i_sb_pl_decode                         (sb_decode),
    .i_sb_src_error                         (lvl[ucie_log_event_pkg::EVT_SB_SRC]),
    .i_sb_dst_error                         (lvl[ucie_log_event_pkg::EVT_SB_DST]),
    .i_sb_opcode_error                      (lvl[ucie_log_event_pkg::EVT_SB_OPCODE]),
    .i_sb_unsupported_message               (lvl[ucie_log_event_pkg::EVT_SB_UNSUPPORTED]),
    .i_sb_parity_error                      (lvl[ucie_log_event_pkg::EVT_SB_PARITY]),
    .i_cntl_parameter_exchange_timeout      (lvl[ucie_log_event_pkg::EVT_PARAM_TIMEOUT]),
    .i_cntl_state_status_transition_timeout (lvl[ucie_log_event_pkg::EVT_STATE_TIMEOUT]),
    .i_cntl_adapter_timeout                 (lvl[ucie_log_event_pkg::EVT_ADAPTER_TIMEOUT]),
    .i_cntl_invalid_parameter_exchange      (lvl[ucie_log_event_pkg::EVT_INVALID_PARAM]),
    .i_tx_over_flow                         (lvl[ucie_log_event_pkg::EVT_TX_OVERFLOW]),
    .i_rx_over_flow                         (lvl[ucie_log_event_pkg::EVT_RX_OVERFLOW]),
    .o_fdi_pl_error                         (fdi_error),
    .o_fdi_pl_cerror                        (fdi_cerror),
    .o_fdi_pl_nferror                       (fdi_nferror),
    .o_fdi_pl_trainerror                    (fdi_trainerror),
    .o_fdi_pl_phyinrecenter                 (fdi_recenter),
    .o_csr_wr                               (csr_wr),
    .o_csr_addr                             (csr_addr),
    .o_csr_wdata                            (csr_wdata)
  );

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // Expected status words for one burst of rising edges
  function automatic void reference_words(
    input  logic [ucie_log_event_pkg::EVT_COUNT-1:0] edges,
    output logic [31:0] int_w,
    output logic [31:0] unc_w,
    output logic [31:0] adp_w
  );
    int_w = '0;
    unc_w = '0;
    adp_w = '0;
    int_w[0] = edges[ucie_log_event_pkg::EVT_SB_SRC];
    int_w[1] = edges[ucie_log_event_pkg::EVT_SB_DST];
    int_w[2] = edges[ucie_log_event_pkg::EVT_SB_OPCODE];
    int_w[3] = edges[ucie_log_event_pkg::EVT_SB_UNSUPPORTED];
    int_w[4] = edges[ucie_log_event_pkg::EVT_SB_PARITY];
    int_w[6] = edges[ucie_log_event_pkg::EVT_TX_OVERFLOW];
    int_w[7] = edges[ucie_log_event_pkg::EVT_RX_OVERFLOW];
    adp_w[0] = edges[ucie_log_event_pkg::EVT_PARAM_TIMEOUT];
    adp_w[1] = edges[ucie_log_event_pkg::EVT_STATE_TIMEOUT];
    unc_w[0] = edges[ucie_log_event_pkg::EVT_ADAPTER_TIMEOUT];
    unc_w[1] = edges[ucie_log_event_pkg::EVT_RX_OVERFLOW];
    unc_w[2] = |int_w;
    unc_w[3] = edges[ucie_log_event_pkg::EVT_SB_FATAL];
    unc_w[4] = edges[ucie_log_event_pkg::EVT_SB_NON_FATAL];
    unc_w[5] = edges[ucie_log_event_pkg::EVT_INVALID_PARAM];
  endfunction

  task automatic check_fdi();
    check_value("o_fdi_pl_error", fdi_error, rdi_error);
    check_value("o_fdi_pl_cerror", fdi_cerror, rdi_cerror);
    check_value("o_fdi_pl_nferror", fdi_nferror, rdi_nferror);
    check_value("o_fdi_pl_trainerror", fdi_trainerror,
                rdi_trainerror | lvl[ucie_log_event_pkg::EVT_INVALID_PARAM]);
    check_value("o_fdi_pl_phyinrecenter", fdi_recenter, rdi_recenter | cntl_recenter);
  endtask

  // Raise the masked levels and note the words they should produce
  task automatic apply_edges(input logic [ucie_log_event_pkg::EVT_COUNT-1:0] mask);
    logic [31:0] rnd;
    logic [31:0] int_w;
    logic [31:0] unc_w;
    logic [31:0] adp_w;
    rnd = $random(seed);
    reference_words(mask, int_w, unc_w, adp_w);
    @(posedge clk);
    lvl <= mask;
    if (mask[ucie_log_event_pkg::EVT_SB_FATAL]) begin
      sb_valid  <= 1'b1;
      sb_decode <= 5'b11110;
    end else if (mask[ucie_log_event_pkg::EVT_SB_NON_FATAL]) begin
      sb_valid  <= 1'b1;
      sb_decode <= 5'b11101;
    end else begin
      // Top bit low never matches an error message
      sb_valid  <= rnd[4];
      sb_decode <= {1'b0, rnd[3:0]};
    end
    exp_int = exp_int | int_w;
    exp_unc = exp_unc | unc_w;
    exp_adp = exp_adp | adp_w;
    @(negedge clk);
    check_fdi();
  endtask

  task automatic release_levels();
    @(posedge clk);
    lvl      <= '0;
    sb_valid <= 1'b0;
  endtask

  task automatic quiet_period();
    repeat (QUIET) @(posedge clk);
    if (exp_int != '0 || exp_unc != '0 || exp_adp != '0) begin
      stop_on_error("An expected status write did not arrive within the quiet period");
    end
  endtask

  task automatic single_event(input int idx);
    logic [ucie_log_event_pkg::EVT_COUNT-1:0] mask;
    mask = '0;
    mask[idx] = 1'b1;
    apply_edges(mask);
    release_levels();
    quiet_period();
  endtask

  // Each write must hit the highest priority pending word with its value
  always @(negedge clk) begin
    if (rst && csr_wr) begin
      write_count = write_count + 1;
      if (exp_int != '0) begin
        check_value("o_csr_addr", csr_addr, ADDR_INT);
      end else if (exp_unc != '0) begin
        check_value("o_csr_addr", csr_addr, ADDR_UNC);
      end else if (exp_adp != '0) begin
        check_value("o_csr_addr", csr_addr, ADDR_ADP);
      end else begin
        stop_on_error("CSR write seen while no error was pending");
      end
      case (csr_addr)
        ADDR_INT: begin
          check_value("o_csr_wdata", csr_wdata, exp_int);
          exp_int = '0;
        end
        ADDR_UNC: begin
          check_value("o_csr_wdata", csr_wdata, exp_unc);
          exp_unc = '0;
        end
        default: begin
          check_value("o_csr_wdata", csr_wdata, exp_adp);
          exp_adp = '0;
        end
      endcase
    end
  end

  // Any failed writer assertion ends the run
  always @(i_dut.u_csr_writer.u_assertions.fail_count) begin
    if (i_dut.u_csr_writer.u_assertions.fail_count != 0) begin
      stop_on_error("An assertion on the CSR writer failed");
    end
  end

  initial begin
    #(TIMEOUT_NS);
    stop_on_error("Watchdog expired before the tests finished");
  end

  initial begin
    logic [ucie_log_event_pkg::EVT_COUNT-1:0] mask;
    logic [31:0] rnd;
    int          wc;
    seed           = 32'h4998;
    rdi_error      = 1'b0;
    rdi_cerror     = 1'b0;
    rdi_nferror    = 1'b0;
    rdi_trainerror = 1'b0;
    rdi_recenter   = 1'b0;
    cntl_recenter  = 1'b0;
    sb_valid       = 1'b0;
    sb_decode      = 5'b0;
    lvl            = '0;
    exp_int        = '0;
    exp_unc        = '0;
    exp_adp        = '0;
    write_count    = 0;
    wait (rst === 1'b1);

    // Idle after reset
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_value("o_csr_wr", csr_wr, 1'b0);
    check_value("o_csr_addr", csr_addr, 8'h00);
    check_value("o_csr_wdata", csr_wdata, 32'h0);
    check_value("write_count", write_count, 0);

    // FDI forwarding with random levels
    repeat (20) begin
      rnd = $random(seed);
      @(posedge clk);
      rdi_error      <= rnd[0];
      rdi_cerror     <= rnd[1];
      rdi_nferror    <= rnd[2];
      rdi_trainerror <= rnd[3];
      rdi_recenter   <= rnd[4];
      cntl_recenter  <= rnd[5];
      @(negedge clk);
      check_fdi();
    end

    // Sideband source error, internal then uncorrectable
    wc = write_count;
    single_event(ucie_log_event_pkg::EVT_SB_SRC);
    check_value("write_count", write_count - wc, 2);

    // Timeouts and sideband messages
    single_event(ucie_log_event_pkg::EVT_ADAPTER_TIMEOUT);
    single_event(ucie_log_event_pkg::EVT_PARAM_TIMEOUT);
    single_event(ucie_log_event_pkg::EVT_STATE_TIMEOUT);
    single_event(ucie_log_event_pkg::EVT_INVALID_PARAM);
    single_event(ucie_log_event_pkg::EVT_SB_FATAL);
    single_event(ucie_log_event_pkg::EVT_SB_NON_FATAL);

    // Matching decodes without valid
    wc = write_count;
    @(posedge clk);
    sb_valid  <= 1'b0;
    sb_decode <= 5'b11110;
    repeat (3) @(posedge clk);
    sb_decode <= 5'b11101;
    quiet_period();
    check_value("write_count", write_count - wc, 0);

    // Held level logs once, a new rise logs again
    wc = write_count;
    mask = '0;
    mask[ucie_log_event_pkg::EVT_SB_PARITY] = 1'b1;
    apply_edges(mask);
    quiet_period();
    repeat (12) @(posedge clk);
    release_levels();
    quiet_period();
    single_event(ucie_log_event_pkg::EVT_SB_PARITY);
    check_value("write_count", write_count - wc, 4);

    // Random bursts
    repeat (NUM_BURSTS) begin
      rnd = $random(seed);
      mask = rnd[ucie_log_event_pkg::EVT_COUNT-1:0];
      if (mask[ucie_log_event_pkg::EVT_SB_FATAL] && mask[ucie_log_event_pkg::EVT_SB_NON_FATAL]) begin
        mask[ucie_log_event_pkg::EVT_SB_FATAL] = 1'b0;
      end
      apply_edges(mask);
      release_levels();
      quiet_period();
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule
